/* Bender.yml */
package:
  name: pdp_mem

sources:
  - files:
      - common/pdp_mem_pkg.sv
      - ram/ram_bank.sv
      - ram/ram_word.sv
      - src/mem_ctrl.sv
      - src/pdp_mem.sv
  - target: test
    files:
      - bench/pdp_mem_sva.sv
      - bench/pdp_mem_tb.sv

/* bench/pdp_mem_sva.sv */
// ##########################################################
// Assertions on the memory bus control, bound to mem_ctrl.
// ##########################################################

`timescale 1ns/10ps

module pdp_mem_sva
(
   input logic                              CLK,
   input logic                              arst_n,
   input logic                              req,
   input pdp_mem_pkg::bus_op_t               op,
   input logic [pdp_mem_pkg::addr_width-1:0] addr,
   input logic                              ce,
   input logic                              we,
   input logic                              done,
   input logic                              err
);

   import pdp_mem_pkg::*;

   reply_excl: assert property (@(posedge CLK) disable iff (!arst_n) !(done && err))
      else $error("done and err high in the same cycle");

   // A write enable needs ce and a write request to existing memory.
   we_in_ce: assert property (@(posedge CLK) disable iff (!arst_n)
                              we |-> ce && req && addr < mem_bytes &&
                                     (op == op_write_word || op == op_write_byte))
      else $error("we high without ce or without a valid write request");

   // Each strobe gets one reply on the next edge.
   req_reply: assert property (@(posedge CLK) disable iff (!arst_n) req |=> (done || err))
      else $error("request left without a reply");

   odd_word_we: assert property (@(posedge CLK) disable iff (!arst_n)
                                 !(we && op == op_write_word && addr[0]))
      else $error("write enable on an odd word address");

endmodule

bind mem_ctrl pdp_mem_sva pdp_mem_sva_i
(
   .CLK    (CLK),
   .arst_n (arst_n),
   .req    (req),
   .op     (op),
   .addr   (addr),
   .ce     (ce),
   .we     (we),
   .done   (done),
   .err    (err)
);

/* bench/pdp_mem_tb.sv */
// ##########################################################
// Testbench for the main memory. Drives directed and random
// strobe requests and checks every reply against a byte model.
// ##########################################################

`timescale 1ns/10ps

module pdp_mem_tb;

   import pdp_mem_pkg::*;

   typedef struct packed
   {
      logic [31:0]           due;
      logic                  done;
      logic                  err;
      logic [data_width-1:0] rdata;
   } reply_t;

   logic                  CLK;
   logic                  arst_n;
   logic                  req;
   bus_op_t               op;
   logic [addr_width-1:0] addr;
   logic [data_width-1:0] wdata;
   logic                  done;
   logic                  err;
   logic [data_width-1:0] rdata;

   logic [byte_width-1:0] model [mem_bytes];   // One entry per byte address.
   reply_t                exp_q [$];
   logic [31:0]           lfsr;
   int                    cycle = 0;
   int                    errors;

   pdp_mem pdp_mem_i
   (
      .CLK    (CLK),
      .arst_n (arst_n),
      .req    (req),
      .op     (op),
      .addr   (addr),
      .wdata  (wdata),
      .done   (done),
      .err    (err),
      .rdata  (rdata)
   );

   initial
   begin
      CLK = 1'b0;
      forever
      begin
         #4 CLK = ~CLK;
      end
   end

   always @(posedge CLK)
   begin
      cycle <= cycle + 1;
   end

   // ##########################################################
   // Helpers
   // ##########################################################

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32, 22, 2, 1.
   endfunction

   function automatic logic [15:0] take_bits(input int n);
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr);
         v    = {v[14:0], lfsr[0]};
      end
      return v;
   endfunction

   // Expected reply for one bus cycle; valid writes update the model.
   function automatic reply_t predict(input logic r, input bus_op_t o,
                                      input logic [addr_width-1:0] a,
                                      input logic [data_width-1:0] d);
      reply_t x;
      logic   bt;
      x  = '0;
      bt = (o == op_read_byte) || (o == op_write_byte);
      if (!r)
      begin
         return x;
      end
      if ((!bt && a[0]) || a >= mem_bytes)
      begin
         x.err = 1'b1;                                 // Odd word or nonexistent.
         return x;
      end
      x.done = 1'b1;
      case (o)
         op_read_word:  x.rdata = {model[a + 1], model[a]};
         op_read_byte:  x.rdata = {8'h00, model[a]};
         op_write_word:
         begin
            model[a]     = d[7:0];
            model[a + 1] = d[15:8];
         end
         default:       model[a] = d[7:0];
      endcase
      return x;
   endfunction

   task automatic fail_now(input string why);
      $display("%s", why);
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [data_width-1:0] got,
                        input logic [data_width-1:0] exp);
      if (got !== exp)
      begin
         errors++;
         fail_now($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   task automatic issue(input logic r, input bus_op_t o, input logic [addr_width-1:0] a,
                        input logic [data_width-1:0] d);
      reply_t x;
      @(posedge CLK);
      #1;
      req   = r;
      op    = o;
      addr  = a;
      wdata = d;
      x     = predict(r, o, a, d);
      x.due = cycle + 1;                               // Reply follows the next edge.
      exp_q.push_back(x);
   endtask

   // ##########################################################
   // Reply checker
   // ##########################################################

   initial
   begin : compare_proc
      reply_t x;
      int     n;
      n = 0;
      while (arst_n !== 1'b1)
      begin
         if (n == 20)
         begin
            fail_now("Reset was never released");
         end
         @(posedge CLK);
         n++;
      end
      #2;
      check("done", done, 16'h0000);
      check("err", err, 16'h0000);
      check("rdata", rdata, 16'h0000);
      forever
      begin
         @(posedge CLK);
         #2;
         if (exp_q.size() > 0 && exp_q[0].due == cycle)
         begin
            x = exp_q.pop_front();
            check("done", done, x.done);
            check("err", err, x.err);
            check("rdata", rdata, x.rdata);
         end
      end
   end

   // ##########################################################
   // Stimulus
   // ##########################################################

   initial
   begin : main_proc
      logic [15:0]           r;
      logic [addr_width-1:0] a;
      int                    n;
      arst_n = 1'b0;
      req    = 1'b0;
      op     = op_read_word;
      addr   = '0;
      wdata  = '0;
      lfsr   = 32'd83195;
      errors = 0;
      for (int i = 0; i < mem_bytes; i++)
      begin
         model[i] = '0;
      end
      repeat (3) @(posedge CLK);
      #1;
      arst_n = 1'b1;

      repeat (4) issue(1'b0, op_read_word, '0, '0);    // Quiet bus after reset.
      for (int i = 0; i < 8; i++)
      begin
         r = take_bits(13);
         a = {2'b00, r[12:0], 1'b0};
         issue(1'b1, op_read_word, a, '0);
      end

      issue(1'b1, op_write_word, 16'h0200, 16'hbeef);
      issue(1'b1, op_read_word, 16'h0200, '0);

      issue(1'b1, op_write_word, 16'h0300, 16'h1234);
      issue(1'b1, op_write_byte, 16'h0300, 16'h77ab);  // Only the low half changes.
      issue(1'b1, op_read_word, 16'h0300, '0);
      issue(1'b1, op_write_byte, 16'h0301, 16'h55cd);
      issue(1'b1, op_read_byte, 16'h0300, '0);
      issue(1'b1, op_read_byte, 16'h0301, '0);
      issue(1'b1, op_read_word, 16'h0300, '0);

      issue(1'b1, op_write_word, 16'h0305, 16'hdead);  // Odd word write is refused.
      issue(1'b1, op_read_word, 16'h0303, '0);
      issue(1'b1, op_read_word, 16'h0304, '0);
      issue(1'b1, op_read_byte, 16'h0305, '0);

      issue(1'b1, op_write_word, 16'h4000, 16'hffff);
      issue(1'b1, op_write_byte, 16'hffff, 16'h00ff);
      issue(1'b1, op_write_word, 16'h8002, 16'h5a5a);
      issue(1'b1, op_read_word, 16'h4000, '0);
      issue(1'b1, op_read_byte, 16'hc001, '0);
      issue(1'b1, op_read_word, 16'h0000, '0);
      issue(1'b1, op_read_word, 16'h0002, '0);
      issue(1'b1, op_read_byte, 16'h3fff, '0);

      for (int i = 0; i < 400; i++)
      begin
         r = take_bits(3);
         case (r[2:0])
            3'd0:
            begin
               a = take_bits(16);                      // Mostly nonexistent.
            end
            3'd1, 3'd2, 3'd3:
            begin
               r = take_bits(14);
               a = {2'b00, r[13:0]};
            end
            default:
            begin
               a = 16'h0100 + take_bits(6);            // Small window for reuse.
            end
         endcase
         r = take_bits(3);
         n = (r[2:0] != 3'd0);
         r = take_bits(2);
         issue(n[0], bus_op_t'(r[1:0]), a, take_bits(16));
      end
      repeat (2) issue(1'b0, op_read_word, '0, '0);

      n = 0;
      while (exp_q.size() > 0)
      begin
         if (n == 10)
         begin
            fail_now("Replies still pending after the last request");
         end
         @(posedge CLK);
         n++;
      end
      if (errors == 0)
      begin
         $display("All tests passed");
      end
      else
      begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

/* common/pdp_mem_pkg.sv */
// ##########################################################
// Shared widths, memory size and bus operation codes for the
// main memory subsystem. Modules import it inside their body.
// ##########################################################

package pdp_mem_pkg;

   // ##########################################################
   // Bus widths
   // ##########################################################

   localparam int addr_width = 16;       // Byte address on the bus.
   localparam int data_width = 16;       // One machine word.
   localparam int byte_width = 8;        // One bank lane.

   // ##########################################################
   // Storage geometry
   // ##########################################################

   localparam int bank_depth      = 8192;   // Words held by each bank.
   localparam int bank_addr_width = 13;     // Index into one bank.

   // Addresses at or above this size are nonexistent memory.
   localparam int mem_bytes = 16384;

   // ##########################################################
   // Request kinds
   // ##########################################################

   typedef enum logic [1:0]
   {
      op_read_word  = 2'b00,
      op_read_byte  = 2'b01,
      op_write_word = 2'b10,
      op_write_byte = 2'b11
   } bus_op_t;

   // Bit 1 of the code marks a write and bit 0 a byte access.

endpackage

/* pdp_mem.f */
common/pdp_mem_pkg.sv
ram/ram_bank.sv
ram/ram_word.sv
src/mem_ctrl.sv
src/pdp_mem.sv
bench/pdp_mem_sva.sv
bench/pdp_mem_tb.sv

/* ram/ram_bank.sv */
// ##########################################################
// One byte lane of main memory. Reads are combinational and
// writes are taken at the rising clock edge.
// ##########################################################

`timescale 1ns/10ps

module ram_bank
(
   input  logic                                   CLK,
   input  logic [pdp_mem_pkg::bank_addr_width-1:0] bank_addr,
   input  logic [pdp_mem_pkg::byte_width-1:0]      bank_wdata,
   input  logic                                   bank_we,
   output logic [pdp_mem_pkg::byte_width-1:0]      bank_rdata
);

   import pdp_mem_pkg::*;

   logic [byte_width-1:0] mem [bank_depth];

   initial
   begin
      for (int i = 0; i < bank_depth; i++)
      begin
         mem[i] = '0;                    // Storage powers up cleared.
      end
   end

   always_ff @(posedge CLK)
   begin
      if (bank_we)
      begin
         mem[bank_addr] <= bank_wdata;
      end
   end

   assign bank_rdata = mem[bank_addr];

endmodule

/* ram/ram_word.sv */
// ##########################################################
// 16-bit word memory made of a high and a low byte bank.
// Steers byte writes to one lane and shapes byte reads.
// ##########################################################

`timescale 1ns/10ps

module ram_word
(
   input  logic                                   CLK,
   input  logic                                   ce,
   input  logic                                   we,
   input  logic                                   byte_op,
   input  logic [pdp_mem_pkg::bank_addr_width:0]   mem_addr,
   input  logic [pdp_mem_pkg::data_width-1:0]      mem_wdata,
   output logic [pdp_mem_pkg::data_width-1:0]      mem_rdata
);

   import pdp_mem_pkg::*;

   logic [bank_addr_width-1:0] bank_addr;
   logic                       odd;
   logic                       we_h;
   logic                       we_l;
   logic [byte_width-1:0]      wdata_h;
   logic [byte_width-1:0]      wdata_l;
   logic [byte_width-1:0]      rdata_h;
   logic [byte_width-1:0]      rdata_l;

   // ##########################################################
   // Lane steering
   // ##########################################################

   assign bank_addr = mem_addr[bank_addr_width:1];    // Word index.
   assign odd       = mem_addr[0];

   // An odd byte lives in the high bank, an even byte in the low bank.
   assign we_h = ce && we && (!byte_op || odd);
   assign we_l = ce && we && (!byte_op || !odd);

   // A byte write always carries its data in the low half of the bus.
   assign wdata_h = byte_op ? mem_wdata[byte_width-1:0] : mem_wdata[data_width-1:byte_width];
   assign wdata_l = mem_wdata[byte_width-1:0];

   // ##########################################################
   // Banks
   // ##########################################################

   ram_bank bank_h
   (
      .CLK        (CLK),
      .bank_addr  (bank_addr),
      .bank_wdata (wdata_h),
      .bank_we    (we_h),
      .bank_rdata (rdata_h)
   );

   ram_bank bank_l
   (
      .CLK        (CLK),
      .bank_addr  (bank_addr),
      .bank_wdata (wdata_l),
      .bank_we    (we_l),
      .bank_rdata (rdata_l)
   );

   // ##########################################################
   // Read shaping
   // ##########################################################

   always_comb
   begin
      if (byte_op)
      begin
         mem_rdata = {{byte_width{1'b0}}, odd ? rdata_h : rdata_l};  // Byte in low half.
      end
      else
      begin
         mem_rdata = {rdata_h, rdata_l};
      end
   end

endmodule

/* src/mem_ctrl.sv */
// ##########################################################
// Bus control for main memory. Checks each strobe request,
// drives the memory enables in the request cycle and
// registers the done or err pulse with the read data.
// ##########################################################

`timescale 1ns/10ps

module mem_ctrl
(
   input  logic                                   CLK,
   input  logic                                   arst_n,
   input  logic                                   req,
   input  pdp_mem_pkg::bus_op_t                    op,
   input  logic [pdp_mem_pkg::addr_width-1:0]      addr,
   input  logic [pdp_mem_pkg::data_width-1:0]      wdata,
   input  logic [pdp_mem_pkg::data_width-1:0]      mem_rdata,
   output logic                                   ce,
   output logic                                   we,
   output logic                                   byte_op,
   output logic [pdp_mem_pkg::bank_addr_width:0]   mem_addr,
   output logic [pdp_mem_pkg::data_width-1:0]      mem_wdata,
   output logic                                   done,
   output logic                                   err,
   output logic [pdp_mem_pkg::data_width-1:0]      rdata
);

   import pdp_mem_pkg::*;

   logic is_write;
   logic is_byte;
   logic odd_word;
   logic nxm;
   logic valid;

   // ##########################################################
   // Request decode
   // ##########################################################

   always_comb
   begin
      is_write = 1'b0;
      is_byte  = 1'b0;
      unique case (op)
         op_read_word:  ;
         op_read_byte:  is_byte = 1'b1;
         op_write_word: is_write = 1'b1;
         op_write_byte:
         begin
            is_write = 1'b1;
            is_byte  = 1'b1;
         end
         default: ;
      endcase
   end

   assign odd_word = !is_byte && addr[0];                // Words must be aligned.
   assign nxm      = addr >= addr_width'(mem_bytes);     // Beyond the fitted memory.
   assign valid    = !odd_word && !nxm;

   // ##########################################################
   // Memory side
   // ##########################################################

   assign ce        = req && valid;
   assign we        = ce && is_write;                    // Rejected writes change nothing.
   assign byte_op   = is_byte;
   assign mem_addr  = addr[bank_addr_width:0];
   assign mem_wdata = wdata;

   // ##########################################################
   // Reply
   // ##########################################################

   // The write above lands at the same edge that loads these flops,
   // so a read in the following cycle already sees the new data.
   always_ff @(posedge CLK or negedge arst_n)
   begin
      if (!arst_n)
      begin
         done  <= 1'b0;
         err   <= 1'b0;
         rdata <= '0;
      end
      else
      begin
         done <= req && valid;
         err  <= req && !valid;
         if (req && valid && !is_write)
         begin
            rdata <= mem_rdata;                          // Capture only valid reads.
         end
         else
         begin
            rdata <= '0;
         end
      end
   end

endmodule

/* src/pdp_mem.sv */
// ##########################################################
// Top level of main memory. Joins the bus control to the
// two-bank word memory; the bus side is a strobe interface.
// ##########################################################

`timescale 1ns/10ps

module pdp_mem
(
   input  logic                                   CLK,
   input  logic                                   arst_n,
   input  logic                                   req,
   input  pdp_mem_pkg::bus_op_t                    op,
   input  logic [pdp_mem_pkg::addr_width-1:0]      addr,
   input  logic [pdp_mem_pkg::data_width-1:0]      wdata,
   output logic                                   done,
   output logic                                   err,
   output logic [pdp_mem_pkg::data_width-1:0]      rdata
);

   import pdp_mem_pkg::*;

   logic                       ce;
   logic                       we;
   logic                       byte_op;
   logic [bank_addr_width:0]   mem_addr;       // Low 14 address bits.
   logic [data_width-1:0]      mem_wdata;
   logic [data_width-1:0]      mem_rdata;

   mem_ctrl mem_ctrl_i
   (
      .CLK       (CLK),
      .arst_n    (arst_n),
      .req       (req),
      .op        (op),
      .addr      (addr),
      .wdata     (wdata),
      .mem_rdata (mem_rdata),
      .ce        (ce),
      .we        (we),
      .byte_op   (byte_op),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .done      (done),
      .err       (err),
      .rdata     (rdata)
   );

   ram_word ram_word_i
   (
      .CLK       (CLK),
      .ce        (ce),
      .we        (we),
      .byte_op   (byte_op),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata)
   );

endmodule
